// ==== spi_pkg.sv ====
/* Shared constants for the SPI master: register map, CR1 and SR bit positions,
   reset values and the widths of the data path, baud divider and edge counter */
package spi_pkg;

    // Bus widths
    localparam int DATA_W = 8;                      // Data and register width
    localparam int ADDR_W = 3;                      // APB address width

    // Register map, anything else answers with PSLVERR
    localparam logic [ADDR_W-1:0] ADDR_CR1 = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_CR2 = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_BR  = 3'd2;
    localparam logic [ADDR_W-1:0] ADDR_SR  = 3'd3;  // Read only
    localparam logic [ADDR_W-1:0] ADDR_DR  = 3'd5;

    // CR1 fields
    localparam int CR1_SPIE  = 7;                   // Rx full and mode fault irq enable
    localparam int CR1_SPE   = 6;                   // SPI enable
    localparam int CR1_SPTIE = 5;                   // Tx empty irq enable
    localparam int CR1_MSTR  = 4;
    localparam int CR1_CPOL  = 3;
    localparam int CR1_CPHA  = 2;
    localparam int CR1_LSBFE = 0;

    // Status fields
    localparam int SR_SPIF  = 7;                    // Receive full
    localparam int SR_SPTEF = 5;                    // Transmit empty
    localparam int SR_MODF  = 4;

    // Reset values
    localparam logic [DATA_W-1:0] CR1_RESET = 8'h04;
    localparam logic [DATA_W-1:0] REG_RESET = 8'h00; // CR2, BR and DR

    // Baud register layout: sppr in BR[6:4], spr in BR[2:0]
    localparam int SPPR_W      = 3;
    localparam int SPR_W       = 3;
    localparam int BR_SPPR_LSB = 4;
    localparam int BR_SPR_LSB  = 0;

    // Half period reaches 8 * 2^8 / 2, one extra bit holds that count itself
    localparam int DIV_W = $clog2(8 * (2 ** 8) / 2) + 1;

    // 16 SCK edges per byte
    localparam int EDGE_W = $clog2(2 * DATA_W);

endpackage

// ==== spi_apb_regs.sv ====
/* APB slave for the SPI master: SETUP/ACCESS FSM, CR1/CR2/BR/DR registers,
   SPIF/SPTEF flags, status word, read mux, transfer start and interrupt */
module spi_apb_regs (
    input  logic                         PCLK,
    input  logic                         PRESETn,
    input  logic                         PSEL,
    input  logic                         PENABLE,
    input  logic                         PWRITE,
    input  logic [spi_pkg::ADDR_W-1:0]   PADDR,
    input  logic [spi_pkg::DATA_W-1:0]   PWDATA,
    input  logic [spi_pkg::DATA_W-1:0]   rx_data,           // Byte from the shifter
    input  logic                         transfer_complete, // One cycle at end of byte
    input  logic                         spi_busy,
    output logic [spi_pkg::DATA_W-1:0]   PRDATA,
    output logic                         PREADY,
    output logic                         PSLVERR,
    output logic                         cpol,
    output logic                         cpha,
    output logic                         lsbfe,
    output logic [spi_pkg::SPPR_W-1:0]   sppr,
    output logic [spi_pkg::SPR_W-1:0]    spr,
    output logic [spi_pkg::DATA_W-1:0]   tx_data,
    output logic                         load_tx,
    output logic                         spi_interrupt_request
);

    logic [spi_pkg::DATA_W-1:0] cr1;
    logic [spi_pkg::DATA_W-1:0] cr2;
    logic [spi_pkg::DATA_W-1:0] br;
    logic [spi_pkg::DATA_W-1:0] dr;
    logic [spi_pkg::DATA_W-1:0] sr;    // Assembled status word
    logic                       sptef; // No byte waiting in DR
    logic                       spif;  // Received byte waiting in DR
    logic                       modf;
    logic                       in_access;
    logic                       mapped;
    logic                       wr_en;
    logic                       rd_en;
    logic                       dr_wr;
    logic                       dr_rd;

    // Two states only, SETUP when low and ACCESS when high
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            in_access <= 1'b0;
        end else if (in_access) begin
            in_access <= 1'b0;              // One ACCESS cycle per transfer
        end else begin
            in_access <= PSEL && PENABLE;   // PENABLE seen, answer next cycle
        end
    end

    always_comb begin
        case (PADDR)
            spi_pkg::ADDR_CR1,
            spi_pkg::ADDR_CR2,
            spi_pkg::ADDR_BR,
            spi_pkg::ADDR_SR,
            spi_pkg::ADDR_DR: mapped = 1'b1;
            default:          mapped = 1'b0;
        endcase
    end

    assign PREADY  = in_access;
    assign PSLVERR = in_access && !mapped;          // Decode error only
    assign wr_en   = in_access && PWRITE && mapped;
    assign rd_en   = in_access && !PWRITE && mapped;
    assign dr_wr   = wr_en && (PADDR == spi_pkg::ADDR_DR);
    assign dr_rd   = rd_en && (PADDR == spi_pkg::ADDR_DR);

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            cr1 <= spi_pkg::CR1_RESET;
            cr2 <= spi_pkg::REG_RESET;
            br  <= spi_pkg::REG_RESET;
            dr  <= spi_pkg::REG_RESET;
        end else begin
            if (wr_en) begin
                case (PADDR)
                    spi_pkg::ADDR_CR1: cr1 <= PWDATA;
                    spi_pkg::ADDR_CR2: cr2 <= PWDATA;
                    spi_pkg::ADDR_BR:  br  <= PWDATA;
                    spi_pkg::ADDR_DR:  dr  <= PWDATA;
                    default:           ;            // SR writes are ignored
                endcase
            end
            // Rx byte lands in DR unless the CPU writes it now or a byte is still queued
            if (transfer_complete && !dr_wr && (sptef || load_tx)) begin
                dr <= rx_data;
            end
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            sptef <= 1'b1;
            spif  <= 1'b0;
        end else begin
            if (load_tx) sptef <= 1'b1;             // Byte handed to the shifter
            if (dr_wr)   sptef <= 1'b0;             // New byte queued, wins over load
            if (dr_rd)   spif  <= 1'b0;
            if (transfer_complete) spif <= 1'b1;    // Fresh data beats a clearing read
        end
    end

    // No slave-select input, so a mode fault cannot be seen
    assign modf = 1'b0;

    // Control fields
    assign cpol    = cr1[spi_pkg::CR1_CPOL];
    assign cpha    = cr1[spi_pkg::CR1_CPHA];
    assign lsbfe   = cr1[spi_pkg::CR1_LSBFE];
    assign sppr    = br[spi_pkg::BR_SPPR_LSB +: spi_pkg::SPPR_W];
    assign spr     = br[spi_pkg::BR_SPR_LSB +: spi_pkg::SPR_W];
    assign tx_data = dr;

    // Start when enabled, master, byte queued and shifter idle
    // spi_busy follows a cycle later and ends the pulse
    assign load_tx = cr1[spi_pkg::CR1_SPE] && cr1[spi_pkg::CR1_MSTR] && !sptef && !spi_busy;

    assign spi_interrupt_request = (cr1[spi_pkg::CR1_SPIE] && spif) ||
                                   (cr1[spi_pkg::CR1_SPTIE] && sptef) ||
                                   (cr1[spi_pkg::CR1_SPIE] && modf);

    always_comb begin
        sr                    = '0;
        sr[spi_pkg::SR_SPIF]  = spif;
        sr[spi_pkg::SR_SPTEF] = sptef;
        sr[spi_pkg::SR_MODF]  = modf;
    end

    // Read data only while PREADY is high, zero otherwise
    always_comb begin
        PRDATA = '0;
        if (rd_en) begin
            case (PADDR)
                spi_pkg::ADDR_CR1: PRDATA = cr1;
                spi_pkg::ADDR_CR2: PRDATA = cr2;
                spi_pkg::ADDR_BR:  PRDATA = br;
                spi_pkg::ADDR_SR:  PRDATA = sr;
                spi_pkg::ADDR_DR:  PRDATA = dr;
                default:           PRDATA = '0;
            endcase
        end
    end

endmodule

// ==== spi_baud_gen.sv ====
/* SCK half-period tick generator, (sppr+1) * 2^spr PCLK cycles per tick */
module spi_baud_gen (
    input  logic                        PCLK,
    input  logic                        PRESETn,
    input  logic                        run,        // High during a transfer
    input  logic [spi_pkg::SPPR_W-1:0]  sppr,       // Prescaler, divide by sppr+1
    input  logic [spi_pkg::SPR_W-1:0]   spr,        // Power-of-two selector
    output logic                        half_tick
);

    logic [spi_pkg::DIV_W-1:0] sppr_ext;
    logic [spi_pkg::DIV_W-1:0] half_period;
    logic [spi_pkg::DIV_W-1:0] cnt_last;
    logic [spi_pkg::DIV_W-1:0] cnt;

    assign sppr_ext    = {{(spi_pkg::DIV_W - spi_pkg::SPPR_W){1'b0}}, sppr};
    assign half_period = (sppr_ext + 1'b1) << spr;  // Largest value 8 << 7
    assign cnt_last    = half_period - 1'b1;

    // Counts only while running, restarts after every tick
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;                              // Next transfer starts a full period
        end else if (cnt >= cnt_last) begin
            cnt <= '0;                              // Also catches a shrunk divider
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign half_tick = run && (cnt >= cnt_last);

endmodule

// ==== spi_shifter.sv ====
/* SPI master shift engine: SCK phase, MOSI out, MISO capture, ss_n
   and the 16-edge counter for one byte in any cpol/cpha mode and bit order */
module spi_shifter (
    input  logic                        PCLK,
    input  logic                        PRESETn,
    input  logic                        load_tx,            // Start pulse from the registers
    input  logic [spi_pkg::DATA_W-1:0]  tx_data,
    input  logic                        cpol,
    input  logic                        cpha,
    input  logic                        lsbfe,
    input  logic                        half_tick,
    input  logic                        miso,
    output logic                        run,
    output logic                        spi_busy,
    output logic [spi_pkg::DATA_W-1:0]  rx_data,
    output logic                        transfer_complete,
    output logic                        sck,
    output logic                        mosi,
    output logic                        ss_n
);

    logic [spi_pkg::DATA_W-1:0] tx_sr;      // Bits still to send
    logic [spi_pkg::DATA_W-1:0] rx_sr;      // Bits received so far
    logic [spi_pkg::DATA_W-1:0] tx_next;
    logic [spi_pkg::DATA_W-1:0] load_next;
    logic [spi_pkg::EDGE_W-1:0] edge_cnt;   // Edges already made in this byte
    logic                       busy;
    logic                       sck_phase;  // SCK relative to its idle level
    logic                       start;
    logic                       leading;
    logic                       last_edge;
    logic                       do_sample;
    logic                       do_shift;
    logic                       tx_bit;
    logic                       load_bit;

    assign start     = load_tx && !busy;
    assign leading   = !edge_cnt[0];        // Even edges leave the idle level
    assign last_edge = &edge_cnt;           // Edge 16, 2*DATA_W is a power of two

    // Mode 0/2 sample leading, drive trailing; mode 1/3 the other way round
    assign do_sample = busy && half_tick && (leading ^ cpha);
    assign do_shift  = busy && half_tick && (cpha ? leading : (!leading && !last_edge));

    // Next bit and the register after it, MSB or LSB first
    assign tx_bit    = lsbfe ? tx_sr[0] : tx_sr[spi_pkg::DATA_W-1];
    assign tx_next   = lsbfe ? (tx_sr >> 1) : (tx_sr << 1);
    assign load_bit  = lsbfe ? tx_data[0] : tx_data[spi_pkg::DATA_W-1];
    assign load_next = lsbfe ? (tx_data >> 1) : (tx_data << 1);

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            busy              <= 1'b0;
            ss_n              <= 1'b1;
            sck_phase         <= 1'b0;
            edge_cnt          <= '0;
            transfer_complete <= 1'b0;
            mosi              <= 1'b0;
        end else begin
            transfer_complete <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                ss_n      <= 1'b0;                      // Select on load
                sck_phase <= 1'b0;
                edge_cnt  <= '0;
                if (!cpha) mosi <= load_bit;            // First bit ahead of first edge
            end else if (busy && half_tick) begin
                sck_phase <= ~sck_phase;
                edge_cnt  <= edge_cnt + 1'b1;           // Wraps to zero after the last edge
                if (do_shift) mosi <= tx_bit;
                if (last_edge) begin
                    busy              <= 1'b0;          // All four change together
                    ss_n              <= 1'b1;
                    transfer_complete <= 1'b1;
                end
            end
        end
    end

    // Shift registers
    always_ff @(posedge PCLK) begin
        if (start) begin
            tx_sr <= cpha ? tx_data : load_next;        // cpha 0 already sent one bit
        end else if (do_shift) begin
            tx_sr <= tx_next;
        end
        if (do_sample) begin
            if (lsbfe) begin
                rx_sr <= {miso, rx_sr[spi_pkg::DATA_W-1:1]};
            end else begin
                rx_sr <= {rx_sr[spi_pkg::DATA_W-2:0], miso};
            end
        end
    end

    assign sck      = cpol ^ sck_phase;     // Idles at cpol
    assign run      = busy;
    assign spi_busy = busy;
    assign rx_data  = rx_sr;                // Complete in the transfer_complete cycle

endmodule

// ==== spi_top.sv ====
/* SPI master top: APB register block, baud generator and shift engine */
module spi_top (
    input  logic                        PCLK,
    input  logic                        PRESETn,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    input  logic                        PWRITE,
    input  logic [spi_pkg::ADDR_W-1:0]  PADDR,
    input  logic [spi_pkg::DATA_W-1:0]  PWDATA,
    output logic [spi_pkg::DATA_W-1:0]  PRDATA,
    output logic                        PREADY,
    output logic                        PSLVERR,
    output logic                        sck,
    output logic                        mosi,
    input  logic                        miso,
    output logic                        ss_n,
    output logic                        spi_interrupt_request
);

    // Registers to shifter
    logic                       cpol;
    logic                       cpha;
    logic                       lsbfe;
    logic [spi_pkg::DATA_W-1:0] tx_data;
    logic                       load_tx;
    // Registers to baud generator
    logic [spi_pkg::SPPR_W-1:0] sppr;
    logic [spi_pkg::SPR_W-1:0]  spr;
    // Shifter back to registers and baud generator
    logic [spi_pkg::DATA_W-1:0] rx_data;
    logic                       transfer_complete;
    logic                       spi_busy;
    logic                       run;
    logic                       half_tick;

    spi_apb_regs regs0 (
        .PCLK(PCLK), .PRESETn(PRESETn),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA),
        .rx_data(rx_data), .transfer_complete(transfer_complete), .spi_busy(spi_busy),
        .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
        .cpol(cpol), .cpha(cpha), .lsbfe(lsbfe),
        .sppr(sppr), .spr(spr),
        .tx_data(tx_data), .load_tx(load_tx),
        .spi_interrupt_request(spi_interrupt_request)
    );

    spi_baud_gen baud0 (
        .PCLK(PCLK), .PRESETn(PRESETn),
        .run(run), .sppr(sppr), .spr(spr),
        .half_tick(half_tick)
    );

    spi_shifter shift0 (
        .PCLK(PCLK), .PRESETn(PRESETn),
        .load_tx(load_tx), .tx_data(tx_data),
        .cpol(cpol), .cpha(cpha), .lsbfe(lsbfe),
        .half_tick(half_tick), .miso(miso),
        .run(run), .spi_busy(spi_busy),
        .rx_data(rx_data), .transfer_complete(transfer_complete),
        .sck(sck), .mosi(mosi), .ss_n(ss_n)
    );

endmodule

// ==== tb_clkgen.sv ====
/* Testbench clock and reset source, 20 ns PCLK and 16-cycle reset */
module tb_clkgen (
    output logic PCLK,
    output logic PRESETn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        PCLK = 1'b0;
        forever #10 PCLK = ~PCLK;       // 20 ns period
    end

    initial begin
        PRESETn = 1'b0;
        repeat (16) @(posedge PCLK);
        PRESETn <= 1'b1;                // Released on a rising edge
    end

endmodule

// ==== tb_spi_top.sv ====
/* SPI master testbench: APB tasks, MISO loopback, LFSR stimulus and
   assertions on registers, APB timing, transfers, baud rate and interrupts */
module tb_spi_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic        PCLK, PRESETn, PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
    logic [2:0]  PADDR;
    logic [7:0]  PWDATA, PRDATA;
    logic        sck, mosi, ss_n, irq;
    logic [7:0]  cr1_val;                       // Last CR1 value written
    int          exp_period;                    // Expected SCK period in PCLK cycles
    logic [31:0] lfsr = 32'h535b_8078;
    int          cyc_cnt = 0;
    int          last_rise = -1;                // -1 while no rise seen in this byte
    int          rise_checks = 0;
    logic        sck_prev = 1'b0;

    tb_clkgen clk_gen0 (.PCLK(PCLK), .PRESETn(PRESETn));

    spi_top dut0 (
        .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
        .PSLVERR(PSLVERR), .sck(sck), .mosi(mosi),
        .miso(mosi),                            // Loopback, rx byte equals tx byte
        .ss_n(ss_n), .spi_interrupt_request(irq)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic expect_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
            else abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    function automatic bit is_mapped(input logic [2:0] a);
        return a inside {spi_pkg::ADDR_CR1, spi_pkg::ADDR_CR2, spi_pkg::ADDR_BR,
                         spi_pkg::ADDR_SR, spi_pkg::ADDR_DR};
    endfunction

    // One APB transfer, SETUP then ACCESS until PREADY
    task automatic apb_access(input logic wr, input logic [2:0] addr, input logic [7:0] wdata,
                              output logic [7:0] rdata);
        int waited;
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= wr;
        PADDR   <= addr;
        PWDATA  <= wdata;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        waited = 0;
        do begin
            @(negedge PCLK);                    // Outputs settled mid cycle
            waited++;
            if (waited > 8) abort_run("APB access got no PREADY");
        end while (!PREADY);
        rdata = PRDATA;
        expect_bit("PSLVERR", PSLVERR, !is_mapped(addr));
        @(posedge PCLK);                        // Write lands on this edge
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        apb_access(1'b1, addr, data, unused);
        if (addr == spi_pkg::ADDR_CR1) cr1_val = data;
        if (addr == spi_pkg::ADDR_BR)           // (sppr+1) * 2^(spr+1)
            exp_period = (int'(data[spi_pkg::BR_SPPR_LSB +: 3]) + 1)
                         << (int'(data[spi_pkg::BR_SPR_LSB +: 3]) + 1);
    endtask

    task automatic check_reg(input string name, input logic [2:0] addr, input logic [7:0] exp);
        logic [7:0] got;
        apb_access(1'b0, addr, 8'h00, got);
        expect_byte(name, got, exp);
    endtask

    // Poll SR until the received byte is flagged, then check and drain it
    task automatic finish_byte(input logic [7:0] b);
        logic [7:0] s;
        int polls;
        polls = 0;
        do begin
            apb_access(1'b0, spi_pkg::ADDR_SR, 8'h00, s);
            polls++;
            if (polls > 10000) abort_run("SPIF was never set after a DR write");
        end while (!s[spi_pkg::SR_SPIF]);
        check_reg("DR", spi_pkg::ADDR_DR, b);
        check_reg("SR", spi_pkg::ADDR_SR, 8'h20);   // SPIF cleared by the DR read
    endtask

    task automatic send_byte(input logic [7:0] b);
        reg_write(spi_pkg::ADDR_DR, b);
        finish_byte(b);
    endtask

    // Transfer must not start while SPE or MSTR is clear
    task automatic hold_idle();
        repeat (40) begin
            @(negedge PCLK);
            expect_bit("ss_n", ss_n, 1'b1);
        end
        check_reg("SR", spi_pkg::ADDR_SR, 8'h00);
    endtask

    // SCK period monitor, rise to rise inside one selected byte
    always @(negedge PCLK) begin
        if (ss_n) begin
            last_rise = -1;
        end else if (sck && !sck_prev) begin
            if (last_rise >= 0) begin
                assert (cyc_cnt - last_rise == exp_period)
                    else abort_run($sformatf("FAILED sck period: got %h, expected %h",
                                             cyc_cnt - last_rise, exp_period));
                rise_checks++;
            end
            last_rise = cyc_cnt;
        end
        sck_prev = sck;
        cyc_cnt++;
    end

    a_ready_after_enable: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (PSEL && PENABLE && !PREADY) |=> PREADY)
        else abort_run("PREADY did not follow the first PENABLE cycle by one cycle");
    a_ready_in_access: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $rose(PREADY) |-> $past(PSEL && PENABLE))
        else abort_run("PREADY rose outside an APB access");
    a_rdata_idle_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !PREADY |-> (PRDATA == 8'h00))
        else abort_run("PRDATA was not zero while PREADY was low");
    a_sck_idle: assert property (@(posedge PCLK) disable iff (!PRESETn)
        ss_n |-> (sck == cr1_val[spi_pkg::CR1_CPOL]))
        else abort_run("sck left its idle level while ss_n was high");
    // With only SPTIE enabled the request mirrors SPTEF
    a_dr_write_clears_sptef: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (PREADY && PWRITE && PADDR == spi_pkg::ADDR_DR && cr1_val[spi_pkg::CR1_SPTIE] &&
         !cr1_val[spi_pkg::CR1_SPIE]) |=> !irq)
        else abort_run("SPTEF stayed set after a DR write");
    a_irq_disabled: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (!cr1_val[spi_pkg::CR1_SPIE] && !cr1_val[spi_pkg::CR1_SPTIE]) |-> !irq)
        else abort_run("Interrupt request raised with both enables clear");

    initial begin
        logic [7:0] d;
        logic [7:0] b;
        logic [7:0] saved [3];
        int         n;
        int         mode;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        cr1_val    = spi_pkg::CR1_RESET;
        exp_period = 2;                         // BR resets to zero
        n = 0;
        while (PRESETn !== 1'b1) begin
            @(posedge PCLK);
            n++;
            if (n > 100) abort_run("Reset was never released");
        end

        // Reset values, read back and unmapped addresses
        check_reg("CR1", spi_pkg::ADDR_CR1, spi_pkg::CR1_RESET);
        check_reg("SR", spi_pkg::ADDR_SR, 8'h20);
        expect_bit("ss_n", ss_n, 1'b1);
        expect_bit("sck", sck, 1'b0);
        expect_bit("mosi", mosi, 1'b0);
        for (int a = 0; a < 3; a++) begin       // CR1, CR2, BR
            take_bits(8, d);
            saved[a] = d;
            reg_write(3'(a), d);
            check_reg("register", 3'(a), d);
        end
        for (int a = 4; a < 8; a++) begin
            if (a != 5) begin
                take_bits(8, d);
                reg_write(3'(a), d);
                check_reg("PRDATA", 3'(a), 8'h00);
            end
        end
        for (int a = 0; a < 3; a++) check_reg("register", 3'(a), saved[a]);
        reg_write(spi_pkg::ADDR_BR, 8'h00);

        // Loopback in all cpol/cpha modes and both bit orders
        for (mode = 0; mode < 8; mode++) begin
            d = 8'h70;                          // SPE, SPTIE, MSTR
            d[spi_pkg::CR1_CPHA]  = mode[0];
            d[spi_pkg::CR1_CPOL]  = mode[1];
            d[spi_pkg::CR1_LSBFE] = mode[2];
            reg_write(spi_pkg::ADDR_CR1, d);
            take_bits(8, b);
            send_byte(b);
        end

        // Random baud settings in mode 0, 7 rise to rise gaps per byte
        reg_write(spi_pkg::ADDR_CR1, 8'h50);
        repeat (4) begin
            take_bits(3, d);
            take_bits(3, b);
            reg_write(spi_pkg::ADDR_BR, {1'b0, d[2:0], 1'b0, b[2:0]});
            n = rise_checks;
            take_bits(8, b);
            send_byte(b);
            if (rise_checks - n != 7) abort_run("Not every sck period of a byte was measured");
        end
        reg_write(spi_pkg::ADDR_BR, 8'h00);

        // Interrupt sources
        reg_write(spi_pkg::ADDR_CR1, 8'h70);
        @(negedge PCLK);
        expect_bit("spi_interrupt_request", irq, 1'b1);
        reg_write(spi_pkg::ADDR_CR1, 8'hd0);    // SPIE only
        @(negedge PCLK);
        expect_bit("spi_interrupt_request", irq, 1'b0);
        take_bits(8, b);
        reg_write(spi_pkg::ADDR_DR, b);
        n = 0;
        while (!irq) begin
            @(negedge PCLK);
            n++;
            if (n > 40000) abort_run("Receive interrupt never came");
        end
        check_reg("SR", spi_pkg::ADDR_SR, 8'ha0);
        check_reg("DR", spi_pkg::ADDR_DR, b);
        @(negedge PCLK);
        expect_bit("spi_interrupt_request", irq, 1'b0);
        reg_write(spi_pkg::ADDR_CR1, 8'h50);
        send_byte(b);

        // Enable gating, the queued byte goes out once both bits are set
        reg_write(spi_pkg::ADDR_CR1, 8'h10);
        take_bits(8, b);
        reg_write(spi_pkg::ADDR_DR, b);
        hold_idle();
        reg_write(spi_pkg::ADDR_CR1, 8'h40);
        hold_idle();
        reg_write(spi_pkg::ADDR_CR1, 8'h50);
        finish_byte(b);

        $display("No errors");
        $finish;
    end

endmodule

// ==== spi_top.f ====
spi_pkg.sv
spi_apb_regs.sv
spi_baud_gen.sv
spi_shifter.sv
spi_top.sv
tb_clkgen.sv
tb_spi_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_spi_top
RTL_TOP    ?= spi_top
FILELIST   ?= spi_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
